// File: all.f
logic/const_cfg_pkg.sv
logic/const_stream_pkg.sv
logic/const_ctrl.sv
logic/const_sample_gen.sv
logic/pkt_framer.sv
logic/const_source_top.sv
verif/tb_clk_gen.sv
verif/const_source_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the constant source testbench with Verilator
# exit status is nonzero on a build error, a crash or a reported failure

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
LOG=sim.log
TOP=const_source_tb

if ! verilator --binary --timing --assert \
    --top-module "$TOP" -Mdir "$OBJ_DIR" -f all.f; then
  echo "verilator build failed"
  exit 1
fi

"./$OBJ_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the log decides pass or fail
if grep -q "Verification failed" "$LOG"; then
  exit 1
fi

exit 0

// File: verif/const_source_tb.sv
/*
  testbench for const_source_top, inputs change on falling edges only.
  the reference model assumes no packet-size write lands while the framer sits at word 0.
*/
`timescale 1ns/1ps

module const_source_tb;

  localparam logic [7:0]  SR_BASE      = 8'd128;
  localparam logic [63:0] BLOCK_ID     = 64'h00C0_57A0_0000_0001;
  localparam int          CNT_WIDTH    = 14;
  localparam int          RESET_CYCLES = 16;
  localparam int unsigned RNG_SEED     = 2;
  localparam logic [31:0] WORDS_MAX    = 32'((1 << CNT_WIDTH) - 1);

  localparam logic [7:0] ADDR_AMP  = SR_BASE + const_cfg_pkg::SR_AMPLITUDE;
  localparam logic [7:0] ADDR_EN   = SR_BASE + const_cfg_pkg::SR_ENABLE;
  localparam logic [7:0] ADDR_SIZE = SR_BASE + const_cfg_pkg::SR_PKT_SIZE;

  // beat targets per phase
  localparam int STREAM_BEATS  = 192;
  localparam int BP_BEATS      = 64;
  localparam int RESTART_BEATS = 80;
  localparam int RESIZE_BEATS  = 120;
  localparam int MID_WORD      = 10;

  // nominal cycles, two per beat at the usual ready rate
  // four per beat under heavy back-pressure, plus two mid-packet waits
  localparam int STIM_CYCLES = RESET_CYCLES + 100 + 2 * STREAM_BEATS + 4 * BP_BEATS
                             + 2 * (RESTART_BEATS + RESIZE_BEATS) + 40 + 4 * 64;
  localparam int CYCLE_LIMIT = 4 * STIM_CYCLES + 200;

  logic                        bus_clk;
  logic                        arst_n;
  const_cfg_pkg::setting_bus_t set;
  logic [1:0]                  rb_addr;
  logic                        o_tready;
  logic [63:0]                 rb_data;
  const_stream_pkg::beat_t     o_beat;
  logic                        o_tvalid;

  // reference model state
  const_stream_pkg::sample_t ref_amp;
  const_stream_pkg::sample_t amp_old;
  logic                      seen_new;
  logic                      ref_en;
  logic                      ref_en_q;
  logic [CNT_WIDTH-1:0]      ref_words;
  logic [CNT_WIDTH-1:0]      len_cur;
  logic [CNT_WIDTH-1:0]      cnt;
  logic [CNT_WIDTH-1:0]      len_now;
  logic                      exp_last;
  logic [63:0]               exp_rb;
  const_stream_pkg::beat_t   beat_q;
  logic                      stall_q;
  int                        acc_cnt;
  int                        pkt_cnt;
  int                        stall_cnt;

  int    mismatch_cnt = 0;
  int    check_cnt = 0;
  int    cycle_cnt = 0;
  int    ready_pct = 75;
  string test_name = "reset state";

  tb_clk_gen #(
    .PERIOD_NS   (20),
    .RESET_CYCLES(RESET_CYCLES)
  ) u_clk_gen (
    .bus_clk(bus_clk),
    .arst_n (arst_n)
  );

  const_source_top #(
    .SR_BASE  (SR_BASE),
    .BLOCK_ID (BLOCK_ID),
    .CNT_WIDTH(CNT_WIDTH)
  ) u_dut (
    .bus_clk (bus_clk),
    .arst_n  (arst_n),
    .set     (set),
    .rb_addr (rb_addr),
    .o_tready(o_tready),
    .rb_data (rb_data),
    .o_beat  (o_beat),
    .o_tvalid(o_tvalid)
  );

  // byte count to words, floor of one word, capped at the counter range
  function automatic logic [CNT_WIDTH-1:0] words_of(input logic [31:0] bytes);
    logic [31:0] words;
    words = bytes >> 2;
    if (words == 32'd0) begin
      words_of = CNT_WIDTH'(1);
    end else if (words > WORDS_MAX) begin
      words_of = '1;
    end else begin
      words_of = CNT_WIDTH'(words);
    end
  endfunction

  // readback value for a selector, from the model registers
  function automatic logic [63:0] rb_expect(input logic [1:0] sel);
    case (sel)
      const_cfg_pkg::RB_AMPLITUDE: rb_expect = 64'(ref_amp);
      const_cfg_pkg::RB_ENABLE:    rb_expect = 64'(ref_en);
      const_cfg_pkg::RB_PKT_SIZE:  rb_expect = 64'(ref_words) << 2;
      default:                     rb_expect = BLOCK_ID;
    endcase
  endfunction

  task automatic note_mismatch(input string what, input logic [63:0] exp,
                               input logic [63:0] act);
    mismatch_cnt++;
    $display("error %s / %s: expected %h, actual %h", test_name, what, exp, act);
  endtask

  // the packet in progress keeps its length, a new one takes the live size
  assign len_now  = (cnt == '0) ? ref_words : len_cur;
  assign exp_last = (cnt == len_now - CNT_WIDTH'(1));

  always @(posedge bus_clk or negedge arst_n) begin
    if (!arst_n) begin
      ref_amp   <= '0;
      amp_old   <= '0;
      seen_new  <= 1'b0;
      ref_en    <= 1'b0;
      ref_en_q  <= 1'b0;
      ref_words <= words_of(const_cfg_pkg::PKT_SIZE_RESET);
      len_cur   <= '0;
      cnt       <= '0;
      exp_rb    <= '0;
      beat_q    <= '0;
      stall_q   <= 1'b0;
      acc_cnt   <= 0;
      pkt_cnt   <= 0;
      stall_cnt <= 0;
    end else begin
      exp_rb   <= rb_expect(rb_addr);
      ref_en_q <= ref_en;
      beat_q   <= o_beat;
      stall_q  <= o_tvalid && !o_tready;
      if (o_tvalid && !o_tready) begin
        stall_cnt <= stall_cnt + 1;
      end
      if (o_tvalid && o_tready) begin
        acc_cnt <= acc_cnt + 1;
        // packets as the DUT marks them
        if (o_beat.last) begin
          pkt_cnt <= pkt_cnt + 1;
        end
        if (o_beat.data == ref_amp) begin
          seen_new <= 1'b1;
        end
      end
      // packet position, cleared whenever the source is off
      if (!ref_en) begin
        cnt <= '0;
      end else if (o_tvalid && o_tready) begin
        if (cnt == '0) begin
          len_cur <= ref_words;
        end
        if (exp_last) begin
          cnt <= '0;
        end else begin
          cnt <= cnt + CNT_WIDTH'(1);
        end
      end
      // register writes, placed last so a write resets seen_new
      if (set.stb && set.addr == ADDR_AMP) begin
        amp_old  <= ref_amp;
        ref_amp  <= set.data;
        seen_new <= 1'b0;
      end
      if (set.stb && set.addr == ADDR_EN) begin
        ref_en <= set.data[0];
      end
      if (set.stb && set.addr == ADDR_SIZE) begin
        ref_words <= words_of(set.data);
      end
    end
  end

  a_readback: assert property (@(posedge bus_clk) disable iff (!arst_n) rb_data == exp_rb)
    else note_mismatch("readback", $sampled(exp_rb), $sampled(rb_data));

  // valid follows the enable register one edge late, stalls included
  a_valid: assert property (@(posedge bus_clk) disable iff (!arst_n) o_tvalid == ref_en_q)
    else note_mismatch("valid", 64'($sampled(ref_en_q)), 64'($sampled(o_tvalid)));

  a_hold: assert property (@(posedge bus_clk) disable iff (!arst_n) stall_q |-> o_beat == beat_q)
    else note_mismatch("stalled beat", 64'($sampled(beat_q)), 64'($sampled(o_beat)));

  // old value allowed only until the first new one goes out
  a_value: assert property (@(posedge bus_clk) disable iff (!arst_n)
    (o_tvalid && o_tready) |-> (o_beat.data == ref_amp || (!seen_new && o_beat.data == amp_old)))
    else note_mismatch("beat value", 64'($sampled(ref_amp)), 64'($sampled(o_beat.data)));

  a_last: assert property (@(posedge bus_clk) disable iff (!arst_n)
    (o_tvalid && o_tready) |-> o_beat.last == exp_last)
    else note_mismatch("last flag", 64'($sampled(exp_last)), 64'($sampled(o_beat.last)));

  always @(posedge bus_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("timeout: stimulus still running after %0d cycles", CYCLE_LIMIT);
      $display("Verification failed");
      $finish;
    end
  end

  // sink ready and readback selector, one process owns both
  task automatic drive_sink();
    forever begin
      @(negedge bus_clk);
      o_tready = (($urandom % 100) < 32'(ready_pct));
      rb_addr  = rb_addr + 2'd1;
    end
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    set.stb  = 1'b1;
    set.addr = addr;
    set.data = data;
    @(negedge bus_clk);
    set = '0;
  endtask

  task automatic idle(input int n);
    repeat (n) @(negedge bus_clk);
  endtask

  task automatic wait_beats(input int n);
    int target;
    target = acc_cnt + n;
    while (acc_cnt < target) @(negedge bus_clk);
  endtask

  // a write issued here lands well inside the packet
  task automatic wait_mid_packet();
    while (cnt != CNT_WIDTH'(MID_WORD)) @(negedge bus_clk);
  endtask

  task automatic confirm(input bit cond, input string what);
    assert (cond) else begin
      check_cnt++;
      $display("check failed in %s: %s", test_name, what);
    end
  endtask

  initial begin
    int pkts;
    int snap;
    logic [31:0] size_bytes;
    void'($urandom(RNG_SEED));
    set      = '0;
    o_tready = 1'b0;
    rb_addr  = 2'd0;
    // sink draws from the seeded stream of this process
    fork
      drive_sink();
    join_none
    wait (arst_n === 1'b1);
    @(negedge bus_clk);
    idle(8);

    test_name = "register readback";
    for (int i = 0; i < 4; i++) begin
      write_reg(ADDR_AMP, $urandom);
      idle(4);
      // bit 0 kept low, streaming is covered later
      write_reg(ADDR_EN, $urandom & 32'hFFFF_FFFE);
      idle(4);
      case (i)
        0:       size_bytes = 32'd0;
        1:       size_bytes = 32'd3;
        2:       size_bytes = $urandom % 65536;
        default: size_bytes = $urandom;
      endcase
      write_reg(ADDR_SIZE, size_bytes);
      idle(4);
    end
    // unmapped addresses around and away from the block
    write_reg(SR_BASE + 8'd3, $urandom);
    idle(4);
    write_reg(SR_BASE - 8'd1, $urandom);
    idle(4);
    write_reg(SR_BASE + 8'd3 + 8'($urandom % 253), $urandom);
    idle(4);

    test_name = "constant stream";
    write_reg(ADDR_SIZE, 32'd256);
    write_reg(ADDR_AMP, 32'hbabababa);
    write_reg(ADDR_EN, 32'd1);
    pkts = pkt_cnt;
    wait_beats(STREAM_BEATS);
    confirm(pkt_cnt - pkts >= 2, "fewer than two packets completed");

    test_name = "back-pressure";
    ready_pct = 30;
    wait_beats(BP_BEATS);
    confirm(stall_cnt > 0, "the sink never stalled a pending beat");
    ready_pct = 75;

    test_name = "disable";
    wait_mid_packet();
    write_reg(ADDR_EN, 32'd0);
    idle(2);
    snap = acc_cnt;
    write_reg(ADDR_AMP, 32'h12345678);
    idle(12);
    confirm(acc_cnt == snap, "beats were accepted while disabled");

    test_name = "change while running";
    write_reg(ADDR_EN, 32'd1);
    pkts = pkt_cnt;
    wait_beats(RESTART_BEATS);
    confirm(pkt_cnt - pkts >= 1, "no packet completed after re-enable");
    write_reg(ADDR_AMP, 32'hdadadada);
    write_reg(ADDR_EN, 32'd1);
    wait_beats(16);
    confirm(seen_new, "new amplitude never reached the stream");
    // 20-word packets from the next boundary on
    wait_mid_packet();
    write_reg(ADDR_SIZE, 32'd80);
    pkts = pkt_cnt;
    wait_beats(RESIZE_BEATS);
    confirm(pkt_cnt - pkts >= 3, "short packets did not follow the size change");
    write_reg(ADDR_EN, 32'd0);
    idle(4);

    $display("errors: %0d mismatches, %0d failed checks (%0d beats, %0d packets)",
             mismatch_cnt, check_cnt, acc_cnt, pkt_cnt);
    if (mismatch_cnt == 0 && check_cnt == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: verif/tb_clk_gen.sv
/*
  clock and reset for the constant source testbench.
  reset is released on a falling edge, away from the sampling edge.
*/
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 16
) (
  output logic bus_clk,
  output logic arst_n
);

  // free-running bus clock
  initial begin
    bus_clk = 1'b0;
    forever #(PERIOD_NS / 2) bus_clk = ~bus_clk;
  end

  // reset held low for a fixed number of rising edges
  initial begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge bus_clk);
    @(negedge bus_clk);
    arst_n = 1'b1;
  end

endmodule

// File: logic/const_source_top.sv
/*
  constant sc16 sample source, single clock domain on bus_clk.
  CNT_WIDTH bounds the packet length, at most 30 bits.
*/
`timescale 1ns/1ps

module const_source_top #(
  parameter logic [7:0]  SR_BASE   = 8'd128,
  parameter logic [63:0] BLOCK_ID  = 64'h00C0_57A0_0000_0001,
  parameter int          CNT_WIDTH = 14
) (
  input  logic                        bus_clk,
  input  logic                        arst_n,
  input  const_cfg_pkg::setting_bus_t set,
  input  logic [1:0]                  rb_addr,
  input  logic                        o_tready,
  output logic [63:0]                 rb_data,
  output const_stream_pkg::beat_t     o_beat,
  output logic                        o_tvalid
);

  const_stream_pkg::sample_t amplitude;
  logic                      enable;
  logic [CNT_WIDTH-1:0]      pkt_words;
  logic                      last_next;
  logic                      xfer;

  // settings and readback
  const_ctrl #(
    .SR_BASE  (SR_BASE),
    .BLOCK_ID (BLOCK_ID),
    .CNT_WIDTH(CNT_WIDTH)
  ) u_ctrl (
    .bus_clk  (bus_clk),
    .arst_n   (arst_n),
    .set      (set),
    .rb_addr  (rb_addr),
    .rb_data  (rb_data),
    .amplitude(amplitude),
    .enable   (enable),
    .pkt_words(pkt_words)
  );

  // output beat register
  const_sample_gen u_sample_gen (
    .bus_clk  (bus_clk),
    .arst_n   (arst_n),
    .amplitude(amplitude),
    .enable   (enable),
    .last_next(last_next),
    .o_tready (o_tready),
    .o_beat   (o_beat),
    .o_tvalid (o_tvalid),
    .xfer     (xfer)
  );

  // packet boundaries
  pkt_framer #(
    .CNT_WIDTH(CNT_WIDTH)
  ) u_framer (
    .bus_clk  (bus_clk),
    .arst_n   (arst_n),
    .pkt_words(pkt_words),
    .enable   (enable),
    .xfer     (xfer),
    .last_next(last_next)
  );

endmodule

// File: logic/pkt_framer.sv
/*
  packet framer, counts transferred words and flags the last word of a packet.
  a new size applies from the next packet. disable restarts the packet.
*/
`timescale 1ns/1ps

module pkt_framer #(
  parameter int CNT_WIDTH = 14
) (
  input  logic                 bus_clk,
  input  logic                 arst_n,
  input  logic [CNT_WIDTH-1:0] pkt_words,
  input  logic                 enable,
  input  logic                 xfer,
  output logic                 last_next
);

  // words of the current packet already transferred
  logic [CNT_WIDTH-1:0] count;
  // packet length captured at the packet start
  logic [CNT_WIDTH-1:0] cur_len;
  logic [CNT_WIDTH-1:0] len_eff;
  logic [CNT_WIDTH-1:0] last_idx;
  logic [CNT_WIDTH-1:0] next_cnt;
  logic                 at_end;

  // at a packet boundary the live size is the one in force
  assign len_eff  = (count == '0) ? pkt_words : cur_len;
  assign last_idx = len_eff - CNT_WIDTH'(1);
  assign next_cnt = count + CNT_WIDTH'(1);

  // beat at index count is the final one
  assign at_end = (count == last_idx);

  // index of the beat loaded on this edge
  // no transfer: it is count, register was empty
  // transfer: count + 1, or word 0 of the next packet
  always_comb begin
    if (!xfer) begin
      last_next = at_end;
    end else if (at_end) begin
      last_next = (pkt_words == CNT_WIDTH'(1));
    end else begin
      last_next = (next_cnt == last_idx);
    end
  end

  // transfer counter, wraps at the packet end
  always_ff @(posedge bus_clk or negedge arst_n) begin
    if (!arst_n) begin
      count <= '0;
    end else if (!enable) begin
      count <= '0;
    end else if (xfer) begin
      count <= at_end ? '0 : next_cnt;
    end
  end

  // follow pkt_words until the first word goes out
  always_ff @(posedge bus_clk or negedge arst_n) begin
    if (!arst_n) begin
      cur_len <= CNT_WIDTH'(1);
    end else if (count == '0) begin
      cur_len <= pkt_words;
    end
  end

endmodule

// File: logic/const_sample_gen.sv
/*
  output stage of the constant source, a single beat register with valid/ready.
  full rate is one beat per cycle. a stalled beat is dropped when enable falls.
*/
`timescale 1ns/1ps

module const_sample_gen (
  input  logic                      bus_clk,
  input  logic                      arst_n,
  input  const_stream_pkg::sample_t amplitude,
  input  logic                      enable,
  input  logic                      last_next,
  input  logic                      o_tready,
  output const_stream_pkg::beat_t   o_beat,
  output logic                      o_tvalid,
  output logic                      xfer
);

  logic load;

  // beat leaves on this edge
  assign xfer = o_tvalid && o_tready;

  // register empty or draining, and the source is on
  // a stalled beat blocks the load, so it keeps its old amplitude
  assign load = enable && (!o_tvalid || o_tready);

  // valid bit
  // disable wins over a pending beat
  always_ff @(posedge bus_clk or negedge arst_n) begin
    if (!arst_n) begin
      o_tvalid <= 1'b0;
    end else if (!enable) begin
      o_tvalid <= 1'b0;
    end else if (load) begin
      o_tvalid <= 1'b1;
    end
  end

  // beat payload
  // only changes on a load, so it holds while stalled
  // last flag comes from the framer for this very beat
  always_ff @(posedge bus_clk) begin
    if (load) begin
      o_beat.data <= amplitude;
      o_beat.last <= last_next;
    end
  end

endmodule

// File: logic/const_ctrl.sv
/*
  register bank of the constant source, writes land one edge after the strobe.
  packet size saturates at 2**CNT_WIDTH-1 words. readback is registered, one cycle.
*/
`timescale 1ns/1ps

module const_ctrl #(
  parameter logic [7:0]  SR_BASE   = 8'd128,
  parameter logic [63:0] BLOCK_ID  = 64'd0,
  parameter int          CNT_WIDTH = 14
) (
  input  logic                        bus_clk,
  input  logic                        arst_n,
  input  const_cfg_pkg::setting_bus_t set,
  input  logic [1:0]                  rb_addr,
  output logic [63:0]                 rb_data,
  output const_stream_pkg::sample_t   amplitude,
  output logic                        enable,
  output logic [CNT_WIDTH-1:0]        pkt_words
);

  // absolute register addresses, wrap within the 8-bit space
  localparam logic [7:0] ADDR_AMPLITUDE = SR_BASE + const_cfg_pkg::SR_AMPLITUDE;
  localparam logic [7:0] ADDR_ENABLE    = SR_BASE + const_cfg_pkg::SR_ENABLE;
  localparam logic [7:0] ADDR_PKT_SIZE  = SR_BASE + const_cfg_pkg::SR_PKT_SIZE;

  // largest word count the framer can hold
  localparam logic [29:0] WORDS_MAX = 30'((64'd1 << CNT_WIDTH) - 64'd1);

  // reset packet size as a word count
  localparam logic [CNT_WIDTH-1:0] PKT_WORDS_RESET =
    CNT_WIDTH'(const_cfg_pkg::PKT_SIZE_RESET >> const_cfg_pkg::BYTES_PER_WORD_LOG2);

  logic                 wr_amplitude;
  logic                 wr_enable;
  logic                 wr_pkt_size;
  logic [29:0]          words_req;
  logic [CNT_WIDTH-1:0] words_new;

  // address decode, strobe qualifies every write
  assign wr_amplitude = set.stb && (set.addr == ADDR_AMPLITUDE);
  assign wr_enable    = set.stb && (set.addr == ADDR_ENABLE);
  assign wr_pkt_size  = set.stb && (set.addr == ADDR_PKT_SIZE);

  // bytes to words, partial words dropped
  assign words_req = set.data[31:2];

  // clamp to one word at the bottom
  // and to the counter range at the top
  always_comb begin
    if (words_req == '0) begin
      words_new = CNT_WIDTH'(1);
    end else if (words_req > WORDS_MAX) begin
      words_new = '1;
    end else begin
      words_new = CNT_WIDTH'(words_req);
    end
  end

  // constant sample word
  always_ff @(posedge bus_clk or negedge arst_n) begin
    if (!arst_n) begin
      amplitude <= '0;
    end else if (wr_amplitude) begin
      amplitude <= const_stream_pkg::sample_t'(set.data);
    end
  end

  // enable level, only bit 0 is kept
  always_ff @(posedge bus_clk or negedge arst_n) begin
    if (!arst_n) begin
      enable <= 1'b0;
    end else if (wr_enable) begin
      enable <= set.data[0];
    end
  end

  // packet length in words
  // framer picks it up at the next packet boundary
  always_ff @(posedge bus_clk or negedge arst_n) begin
    if (!arst_n) begin
      pkt_words <= PKT_WORDS_RESET;
    end else if (wr_pkt_size) begin
      pkt_words <= words_new;
    end
  end

  // registered readback mux
  // all fields zero-extended to 64 bits
  always_ff @(posedge bus_clk or negedge arst_n) begin
    if (!arst_n) begin
      rb_data <= '0;
    end else begin
      case (rb_addr)
        const_cfg_pkg::RB_AMPLITUDE: rb_data <= 64'(amplitude);
        const_cfg_pkg::RB_ENABLE:    rb_data <= 64'(enable);
        // size goes back out in bytes
        const_cfg_pkg::RB_PKT_SIZE:  rb_data <= 64'({pkt_words, 2'b00});
        const_cfg_pkg::RB_BLOCK_ID:  rb_data <= BLOCK_ID;
      endcase
    end
  end

endmodule

// File: logic/const_stream_pkg.sv
/*
  stream types of the constant source.
  one beat carries exactly one sc16 sample, no headers or stream ids.
*/
package const_stream_pkg;

  // sc16 sample, i in [31:16] and q in [15:0]
  // a 32-bit amplitude word maps straight onto this layout
  typedef struct packed {
    logic [15:0] i;
    logic [15:0] q;
  } sample_t;

  // one stream beat
  // last marks the final word of a packet
  typedef struct packed {
    sample_t data;
    logic    last;
  } beat_t;

endpackage

// File: logic/const_cfg_pkg.sv
/*
  settings bus and register map of the constant source.
  register offsets are relative to SR_BASE, a parameter of the control module.
*/
package const_cfg_pkg;

  // one register write, valid for the single cycle where stb is high
  // no acknowledge, no back-pressure on this bus
  typedef struct packed {
    logic        stb;
    logic [7:0]  addr;
    logic [31:0] data;
  } setting_bus_t;

  // setting register offsets, added to SR_BASE
  // amplitude word, sc16 with i in the upper half
  localparam logic [7:0] SR_AMPLITUDE = 8'd0;
  // enable level, bit 0 only
  localparam logic [7:0] SR_ENABLE    = 8'd1;
  // packet size in bytes
  // truncated to whole words, never below one word
  localparam logic [7:0] SR_PKT_SIZE  = 8'd2;

  // readback selectors on rb_addr
  localparam logic [1:0] RB_AMPLITUDE = 2'd0;
  localparam logic [1:0] RB_ENABLE    = 2'd1;
  // returned in bytes, so a whole number of words times four
  localparam logic [1:0] RB_PKT_SIZE  = 2'd2;
  localparam logic [1:0] RB_BLOCK_ID  = 2'd3;

  // packet size after reset, in bytes
  // 64 bytes is 16 sc16 words
  localparam logic [31:0] PKT_SIZE_RESET = 32'd64;

  // bytes per sc16 word, as a shift
  localparam int unsigned BYTES_PER_WORD_LOG2 = 2;

endpackage
